// File: compile.f
hw/mdio_pkg.sv
hw/mdio_mgmt_if.sv
hw/apb_mdio_regs.sv
hw/mdio_transceiver.sv
hw/apb_mdio_top.sv
dv/mdio_phy_model.sv
dv/tb_apb_mdio.sv

// File: dv/mdio_phy_model.sv
`timescale 1ns/100ps

module mdio_phy_model
	import mdio_pkg::*;
#(
	// Single PHY address this model answers at
	parameter logic [4:0] phy_addr = 5'h03
) (
	input  logic mdc,
	input  logic mdio_tx_data,
	input  logic mdio_tx_en,

	// Read data toward the shared line
	output logic drive_en,
	output logic drive_data
);

	// Register file
	logic [15:0] regs [32];

	// Frame decode, bit index counted from the start 0
	logic        active;
	logic        own_read;
	int unsigned cnt;
	logic [13:0] hdr;
	logic [15:0] dat;

	// Last captured frame
	mdio_op_t    last_op;
	logic [4:0]  last_phy;
	logic [4:0]  last_reg;
	logic [15:0] last_data;
	int unsigned frame_cnt;

	initial begin
		// Fill pattern built from the full register index
		for (int i = 0; i < 32; i++)
			regs[i] = 16'h4d00 | 16'(i * 5);
		active     = 1'b0;
		own_read   = 1'b0;
		cnt        = 0;
		frame_cnt  = 0;
		last_op    = OP_WRITE;
		last_phy   = '0;
		last_reg   = '0;
		last_data  = '0;
		drive_en   = 1'b0;
		drive_data = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Sample station bits on rising MDC

	always @(posedge mdc) begin
		if (!active) begin
			// First 0 after the preamble is the start bit
			if (mdio_tx_en && !mdio_tx_data) begin
				active = 1'b1;
				cnt    = 1;
				hdr    = '0;
			end
		end else begin
			// Header bits 1..13, then skip turnaround, then data
			if (cnt < 14)
				hdr = {hdr[12:0], mdio_tx_data};
			else if (cnt >= 16)
				dat = {dat[14:0], mdio_tx_data};
			// Header complete, decide whether to answer
			if (cnt == 13)
				own_read = (hdr[11:10] == OP_READ) && (hdr[9:5] == phy_addr);
			cnt++;
			if (cnt == 32) begin
				last_op  = mdio_op_t'(hdr[11:10]);
				last_phy = hdr[9:5];
				last_reg = hdr[4:0];
				// Nobody drives a foreign read, pull-up gives all ones
				if (last_op == OP_READ) begin
					last_data = own_read ? regs[last_reg] : 16'hffff;
				end else begin
					last_data = dat;
					if (last_phy == phy_addr)
						regs[last_reg] = dat;
				end
				frame_cnt++;
				active     = 1'b0;
				own_read   = 1'b0;
				drive_en   = 1'b0;
				drive_data = 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Drive read bits in the low half of MDC

	always @(negedge mdc) begin
		// Second turnaround bit is 0, then data MSB first
		if (active && own_read && (cnt >= 15)) begin
			drive_en   = 1'b1;
			drive_data = (cnt == 15) ? 1'b0 : regs[hdr[4:0]][31 - cnt];
		end else begin
			drive_en   = 1'b0;
			drive_data = 1'b1;
		end
	end

endmodule

// File: dv/tb_apb_mdio.sv
`timescale 1ns/100ps

module tb_apb_mdio
	import mdio_pkg::*;
();

	// Poll bound for pready and busy
	localparam int poll_limit = 2000;

	// Fields the PHY model records per frame
	typedef struct packed {
		mdio_op_t    op;
		logic [4:0]  phy;
		logic [4:0]  regn;
		logic [15:0] data;
	} frame_t;

	logic      apb;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	logic      pready;
	logic      pslverr;
	apb_data_t prdata;
	logic      mdio_tx_data;
	logic      mdio_tx_en;
	logic      mdio_rx_data;
	logic      mdc;
	logic      phy_drv_en;
	logic      phy_drv_data;

	// Expected PHY 3 register contents and registers written so far
	logic [15:0] shadow [32];
	logic [4:0]  written [$];

	// Frames the sequence has started so far
	int unsigned frames_sent;

	// Station first, then PHY, else pull-up
	assign mdio_rx_data = mdio_tx_en ? mdio_tx_data : (phy_drv_en ? phy_drv_data : 1'b1);

	apb_mdio_top #(
		.clk_div (8)
	) dut (
		.apb          (apb),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.prdata       (prdata),
		.mdio_tx_data (mdio_tx_data),
		.mdio_tx_en   (mdio_tx_en),
		.mdio_rx_data (mdio_rx_data),
		.mdc          (mdc)
	);

	mdio_phy_model #(
		.phy_addr (5'h03)
	) u_phy (
		.mdc          (mdc),
		.mdio_tx_data (mdio_tx_data),
		.mdio_tx_en   (mdio_tx_en),
		.drive_en     (phy_drv_en),
		.drive_data   (phy_drv_data)
	);

	initial begin
		apb = 1'b0;
		forever #2 apb = ~apb;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and compares

	function automatic frame_t expected_frame(input mdio_op_t op, input logic [4:0] phy,
			input logic [4:0] regn, input logic [15:0] data);
		frame_t f;
		f.op   = op;
		f.phy  = phy;
		f.regn = regn;
		// Reads see the PHY register, or the pull-up when no PHY answers
		if (op == OP_WRITE)
			f.data = data;
		else if (phy == 5'h03)
			f.data = shadow[regn];
		else
			f.data = 16'hffff;
		return f;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_op(input string name, input mdio_op_t got, input mdio_op_t exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Captured frame against the reference
	task automatic compare_capture(input frame_t exp);
		// Exactly one new frame since the previous compare
		frames_sent++;
		check_data("frame_cnt", apb_data_t'(u_phy.frame_cnt), apb_data_t'(frames_sent));
		check_op("last_op", u_phy.last_op, exp.op);
		check_data("last_phy", apb_data_t'(u_phy.last_phy), apb_data_t'(exp.phy));
		check_data("last_reg", apb_data_t'(u_phy.last_reg), apb_data_t'(exp.regn));
		check_data("last_data", apb_data_t'(u_phy.last_data), apb_data_t'(exp.data));
	endtask

	//////////////////////////////////////////////////////////////////////
	// APB transfers

	// Setup then access phase with the response sampled on the falling edge
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			input logic exp_err, output apb_data_t rdata);
		int n;
		@(posedge apb);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge apb);
		penable <= 1'b1;
		n = 0;
		@(negedge apb);
		while (!pready) begin
			if (n == poll_limit)
				report_failure("Timeout, pready never rose in the access phase");
			n++;
			@(negedge apb);
		end
		rdata = prdata;
		check_bit($sformatf("pslverr at 0x%h", addr), pslverr, exp_err);
		@(posedge apb);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
		apb_data_t unused;
		apb_xfer(1'b1, addr, data, exp_err, unused);
	endtask

	task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
		apb_xfer(1'b0, addr, '0, exp_err, data);
	endtask

	// Busy polling until the frame is done
	task automatic wait_idle();
		apb_data_t st;
		int n;
		n = 0;
		apb_read(STATUS, 1'b0, st);
		while (st[0]) begin
			if (n == poll_limit)
				report_failure("Timeout, busy never cleared after an MDIO frame");
			n++;
			apb_read(STATUS, 1'b0, st);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		apb_data_t   rd;
		apb_data_t   wd;
		frame_t      f;
		logic [4:0]  r;
		logic [15:0] d;
		void'($urandom(67));
		frames_sent = 0;
		rst_n   <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		repeat (8) @(posedge apb);
		rst_n <= 1'b1;

		// Reset state
		apb_read(STATUS, 1'b0, rd);
		check_data("STATUS", rd, 32'h0);
		apb_read(STATUS2, 1'b0, rd);
		check_data("STATUS2", rd, 32'h0);
		apb_read(CMD_ADDR, 1'b0, rd);
		check_data("CMD_ADDR", rd, 32'h0);
		check_bit("mdio_tx_en", mdio_tx_en, 1'b0);
		check_data("frame_cnt", apb_data_t'(u_phy.frame_cnt), 32'h0);

		// Write frames to PHY 3
		repeat (20) begin
			r = 5'($urandom());
			d = 16'($urandom());
			apb_write(CMD_ADDR, 32'h8000 | {r, 8'h03}, 1'b0);
			apb_write(DATA, {16'h0, d}, 1'b0);
			wait_idle();
			compare_capture(expected_frame(OP_WRITE, 5'h03, r, d));
			check_data("phy reg", apb_data_t'(u_phy.regs[r]), {16'h0, d});
			shadow[r] = d;
			written.push_back(r);
		end

		// Read back from registers written above
		repeat (10) begin
			r = written[$urandom_range(written.size() - 1)];
			apb_write(CMD_ADDR, {19'h0, r, 8'h03}, 1'b0);
			wait_idle();
			f = expected_frame(OP_READ, 5'h03, r, 16'h0);
			apb_read(DATA, 1'b0, rd);
			check_data("DATA", rd, {16'h0, f.data});
			compare_capture(f);
		end

		// No PHY at address 7
		apb_write(CMD_ADDR, {19'h0, r, 8'h07}, 1'b0);
		wait_idle();
		f = expected_frame(OP_READ, 5'h07, r, 16'h0);
		apb_read(DATA, 1'b0, rd);
		check_data("DATA", rd, {16'h0, f.data});
		compare_capture(f);

		// Command readback with write bit and spare bits as zero
		wd = $urandom() | 32'h8000;
		apb_write(CMD_ADDR, wd, 1'b0);
		apb_read(CMD_ADDR, 1'b0, rd);
		check_data("CMD_ADDR", rd, {19'h0, wd[12:8], 3'h0, wd[4:0]});

		// Status and bus errors while a frame runs
		r = written[0];
		d = 16'($urandom());
		apb_write(CMD_ADDR, 32'h8000 | {r, 8'h03}, 1'b0);
		apb_write(DATA, {16'h0, d}, 1'b0);
		apb_read(STATUS, 1'b0, rd);
		check_data("STATUS", rd, 32'h1);
		apb_read(STATUS2, 1'b0, rd);
		check_data("STATUS2", rd, 32'h1);
		apb_read(8'h10, 1'b1, rd);
		apb_write(8'h10, 32'h0, 1'b1);
		apb_read(8'h84, 1'b1, rd);
		apb_write(8'hff, 32'h0, 1'b1);
		apb_write(STATUS, 32'h0, 1'b1);
		apb_write(STATUS2, 32'h0, 1'b1);
		wait_idle();
		compare_capture(expected_frame(OP_WRITE, 5'h03, r, d));
		shadow[r] = d;

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: hw/apb_mdio_regs.sv
`timescale 1ns/100ps

module apb_mdio_regs
	import mdio_pkg::*;
(
	input  logic       apb,
	input  logic       rst_n,

	// APB completer
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  apb_addr_t  paddr,
	input  apb_data_t  pwdata,
	output logic       pready,
	output logic       pslverr,
	output apb_data_t  prdata,

	// Toward the transceiver
	mdio_mgmt_if.host  mgmt
);

	// Accepted writes per register
	logic wr_cmd;
	logic wr_dat;

	//////////////////////////////////////////////////////////////////////
	// Access phase decode

	// Write strobes only in the access phase
	assign wr_cmd = pready && pwrite && (paddr == CMD_ADDR);
	assign wr_dat = pready && pwrite && (paddr == DATA);

	always_comb begin
		// Zero wait states
		pready  = psel && penable;

		// Defaults, no data and no error
		prdata  = '0;
		pslverr = 1'b0;

		if (pready) begin
			if (pwrite) begin
				case (paddr)
					// Only command and data are writable
					CMD_ADDR, DATA: begin
						pslverr = 1'b0;
					end
					// Status is read only, rest unmapped
					default: pslverr = 1'b1;
				endcase
			end else begin
				case (paddr)
					// Command readback, write bit reads as zero
					CMD_ADDR: begin
						prdata[CMD_REG_MSB:CMD_REG_LSB] = mgmt.reg_addr;
						prdata[CMD_PHY_MSB:CMD_PHY_LSB] = mgmt.md_addr;
					end
					// Last read result, stale while busy
					DATA: prdata[DATA_BITS-1:0] = mgmt.rd_data;
					// Busy flag mirrored at two addresses
					STATUS, STATUS2: prdata[0] = mgmt.busy;
					default: pslverr = 1'b1;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Latched fields and command strobe

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			mgmt.start    <= 1'b0;
			mgmt.op       <= OP_WRITE;
			mgmt.md_addr  <= '0;
			mgmt.reg_addr <= '0;
			mgmt.wr_data  <= '0;
		end else begin
			// Strobe lasts one cycle
			mgmt.start <= 1'b0;

			// Address update, read kicked off when write bit clear
			if (wr_cmd) begin
				mgmt.reg_addr <= pwdata[CMD_REG_MSB:CMD_REG_LSB];
				mgmt.md_addr  <= pwdata[CMD_PHY_MSB:CMD_PHY_LSB];
				if (!pwdata[CMD_WRITE_BIT]) begin
					mgmt.start <= 1'b1;
					mgmt.op    <= OP_READ;
				end
			end

			// Data write always starts a write frame
			if (wr_dat) begin
				mgmt.wr_data <= pwdata[DATA_BITS-1:0];
				mgmt.start   <= 1'b1;
				mgmt.op      <= OP_WRITE;
			end
		end
	end

endmodule

// File: hw/apb_mdio_top.sv
`timescale 1ns/100ps

module apb_mdio_top
	import mdio_pkg::*;
#(
	// apb cycles per MDC period
	parameter int clk_div = 16
) (
	input  logic      apb,
	input  logic      rst_n,

	// APB completer port
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output logic      pready,
	output logic      pslverr,
	output apb_data_t prdata,

	// MDIO pins toward the external buffer
	output logic      mdio_tx_data,
	output logic      mdio_tx_en,
	input  logic      mdio_rx_data,
	output logic      mdc
);

	// Command and status link
	mdio_mgmt_if mgmt ();

	//////////////////////////////////////////////////////////////////////
	// Register block

	apb_mdio_regs u_regs (
		.apb     (apb),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pready  (pready),
		.pslverr (pslverr),
		.prdata  (prdata),
		.mgmt    (mgmt.host)
	);

	//////////////////////////////////////////////////////////////////////
	// Frame engine

	mdio_transceiver #(
		.clk_div (clk_div)
	) u_xcvr (
		.apb          (apb),
		.rst_n        (rst_n),
		.mgmt         (mgmt.engine),
		.mdio_tx_data (mdio_tx_data),
		.mdio_tx_en   (mdio_tx_en),
		.mdc          (mdc),
		.mdio_rx_data (mdio_rx_data)
	);

endmodule

// File: hw/mdio_mgmt_if.sv
`timescale 1ns/100ps

interface mdio_mgmt_if
	import mdio_pkg::*;
();

	// Target PHY and register
	logic [4:0]           md_addr;
	logic [4:0]           reg_addr;

	// Payload in both directions
	logic [DATA_BITS-1:0] wr_data;
	logic [DATA_BITS-1:0] rd_data;

	// Single cycle command strobe, op valid alongside
	logic                 start;
	mdio_op_t             op;

	// High while a frame is on the wire
	logic                 busy;

	// Register block side
	modport host (
		output md_addr,
		output reg_addr,
		output wr_data,
		output start,
		output op,
		input  rd_data,
		input  busy
	);

	// Frame engine side
	modport engine (
		input  md_addr,
		input  reg_addr,
		input  wr_data,
		input  start,
		input  op,
		output rd_data,
		output busy
	);

endinterface

// File: hw/mdio_pkg.sv
package mdio_pkg;

	// Bus widths fixed at 8 bit address, 32 bit data
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Register map, writable registers sit 0x20 apart
	typedef enum logic [7:0] {
		CMD_ADDR = 8'h00,
		DATA     = 8'h20,
		STATUS   = 8'h40,
		STATUS2  = 8'h60
	} regid_t;

	// Clause 22 opcodes as sent on the wire
	typedef enum logic [1:0] {
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} mdio_op_t;

	// Frame sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_HEADER,
		ST_TURNAROUND,
		ST_DATA
	} xcvr_state_t;

	//////////////////////////////////////////////////////////////////////
	// Frame fields, 64 MDC periods in all

	localparam int PREAMBLE_BITS   = 32;
	// Start, opcode, PHY address, register address
	localparam int HEADER_BITS     = 14;
	localparam int TURNAROUND_BITS = 2;
	localparam int DATA_BITS       = 16;

	//////////////////////////////////////////////////////////////////////
	// Command register layout

	localparam int CMD_WRITE_BIT = 15;
	localparam int CMD_REG_MSB   = 12;
	localparam int CMD_REG_LSB   = 8;
	localparam int CMD_PHY_MSB   = 4;
	localparam int CMD_PHY_LSB   = 0;

endpackage

// File: hw/mdio_transceiver.sv
`timescale 1ns/100ps

module mdio_transceiver
	import mdio_pkg::*;
#(
	// apb cycles per MDC period, even and at least 4
	parameter int clk_div = 16
) (
	input  logic        apb,
	input  logic        rst_n,

	// From the register block
	mdio_mgmt_if.engine mgmt,

	// MDIO pins, tristate buffer outside
	output logic        mdio_tx_data,
	output logic        mdio_tx_en,
	output logic        mdc,
	input  logic        mdio_rx_data
);

	localparam int phase_w = $clog2(clk_div);
	localparam int cnt_w   = $clog2(PREAMBLE_BITS);
	localparam int word_w  = HEADER_BITS + TURNAROUND_BITS + DATA_BITS;

	// MDC rises halfway, period wraps at the last phase
	localparam logic [phase_w-1:0] phase_rise = phase_w'(clk_div / 2);
	localparam logic [phase_w-1:0] phase_last = phase_w'(clk_div - 1);

	xcvr_state_t          state;
	logic [phase_w-1:0]   phase;
	logic [cnt_w-1:0]     bit_cnt;
	logic                 is_read;

	// Outgoing bits after the preamble, and incoming read data
	logic [word_w-1:0]    shift_word;
	logic [DATA_BITS-1:0] rx_shift;
	logic [DATA_BITS-1:0] rx_next;

	// Period markers
	logic                 fall_pt;
	logic                 rise_pt;
	logic                 end_pt;
	logic                 sample_pt;
	logic                 load;
	logic                 bit_last;
	logic                 drive_en;

	//////////////////////////////////////////////////////////////////////
	// Phase markers and per state bit limits

	assign load      = (state == ST_IDLE) && mgmt.start;
	assign fall_pt   = (state != ST_IDLE) && (phase == '0);
	assign rise_pt   = (state != ST_IDLE) && (phase == phase_rise);
	assign end_pt    = (state != ST_IDLE) && (phase == phase_last);
	// Read data only in the data phase of a read
	assign sample_pt = rise_pt && (state == ST_DATA) && is_read;
	assign rx_next   = {rx_shift[DATA_BITS-2:0], mdio_rx_data};

	// PHY owns the line for turnaround and data of a read
	assign drive_en  = !(is_read && ((state == ST_TURNAROUND) || (state == ST_DATA)));

	always_comb begin
		case (state)
			ST_PREAMBLE:   bit_last = (bit_cnt == cnt_w'(PREAMBLE_BITS - 1));
			ST_HEADER:     bit_last = (bit_cnt == cnt_w'(HEADER_BITS - 1));
			ST_TURNAROUND: bit_last = (bit_cnt == cnt_w'(TURNAROUND_BITS - 1));
			ST_DATA:       bit_last = (bit_cnt == cnt_w'(DATA_BITS - 1));
			default:       bit_last = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge apb) begin
		// Start 01, opcode, addresses, turnaround 10, write data
		if (load)
			shift_word <= {2'b01, mgmt.op, mgmt.md_addr, mgmt.reg_addr, 2'b10, mgmt.wr_data};
		else if (end_pt && (state != ST_PREAMBLE))
			shift_word <= shift_word << 1;

		if (sample_pt)
			rx_shift <= rx_next;
	end

	//////////////////////////////////////////////////////////////////////
	// Frame sequencer

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			state        <= ST_IDLE;
			phase        <= '0;
			bit_cnt      <= '0;
			is_read      <= 1'b0;
			mgmt.busy    <= 1'b0;
			mgmt.rd_data <= '0;
			mdc          <= 1'b0;
			mdio_tx_en   <= 1'b0;
			mdio_tx_data <= 1'b1;
		end else if (state == ST_IDLE) begin
			// Bus parked, line released high
			mdc          <= 1'b0;
			mdio_tx_en   <= 1'b0;
			mdio_tx_data <= 1'b1;
			phase        <= '0;
			bit_cnt      <= '0;
			// New commands only accepted here
			if (load) begin
				is_read   <= (mgmt.op == OP_READ);
				mgmt.busy <= 1'b1;
				state     <= ST_PREAMBLE;
			end
		end else begin
			phase <= (phase == phase_last) ? '0 : phase + 1'b1;

			// Start of low half, present next bit
			if (fall_pt) begin
				mdc          <= 1'b0;
				mdio_tx_en   <= drive_en;
				mdio_tx_data <= (state == ST_PREAMBLE) ? 1'b1 : shift_word[word_w-1];
			end

			// PHY samples here, and so do we on reads
			if (rise_pt)
				mdc <= 1'b1;

			// Result goes out before busy drops
			if (sample_pt && bit_last)
				mgmt.rd_data <= rx_next;

			// Bit counting and state advance at period end
			if (end_pt) begin
				if (bit_last) begin
					bit_cnt <= '0;
					case (state)
						ST_PREAMBLE:   state <= ST_HEADER;
						ST_HEADER:     state <= ST_TURNAROUND;
						ST_TURNAROUND: state <= ST_DATA;
						default: begin
							state     <= ST_IDLE;
							mgmt.busy <= 1'b0;
						end
					endcase
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule
